//--- source/led_matrix_pkg.sv
// Shared widths, plane count and UART command codes for the LED matrix controller
package led_matrix_pkg;

	// Brightness bit planes per frame
	// Plane p is shown for OE_BASE_CYCLES << p cycles
	localparam int PLANES = 6;

	// One UART byte
	localparam int BYTE_W = 8;

	// RGB565 pixel word
	// Red 15..11, green 10..5, blue 4..0
	localparam int PIXEL_W = 16;

	// Line write
	// Followed by a row byte, then two bytes per column, low byte first
	localparam logic [BYTE_W-1:0] CMD_LINE = 8'h4C;

	// Brightness enable
	// Followed by one byte, bits 5..0 gate the planes
	localparam logic [BYTE_W-1:0] CMD_ENABLE = 8'h45;

endpackage

//--- source/uart_byte_rx.sv
// UART receiver for 8N1 frames, emits each good byte with a one-cycle strobe
`timescale 1ns/10ps

module uart_byte_rx #(
	parameter int TICKS_PER_BIT = 20
) (
	input  logic clk_root,
	input  logic rst_n,
	input  logic uart_rx,
	output logic [led_matrix_pkg::BYTE_W-1:0] rx_data,
	output logic rx_strobe
);
	import led_matrix_pkg::*;

	localparam int TICK_W = $clog2(TICKS_PER_BIT);
	localparam int HALF_BIT = TICKS_PER_BIT / 2;
	localparam logic [1:0] ST_IDLE = 2'd0;
	localparam logic [1:0] ST_START = 2'd1;
	localparam logic [1:0] ST_DATA = 2'd2;
	localparam logic [1:0] ST_STOP = 2'd3;

	logic [1:0] rx_sync;
	logic rx_bit;
	logic [1:0] state;
	logic [TICK_W-1:0] tick;
	logic bit_done;
	logic [$clog2(BYTE_W)-1:0] bit_idx;
	logic [BYTE_W-1:0] shift;

	// Line idles high
	assign rx_bit = rx_sync[1];
	// Last tick of a full bit period, lands mid-bit after the half-bit start wait
	assign bit_done = (tick == TICK_W'(TICKS_PER_BIT - 1));

	// Two flops for the asynchronous line
	always_ff @(posedge clk_root) begin
		if (!rst_n) begin
			rx_sync <= 2'b11;
		end else begin
			rx_sync <= {rx_sync[0], uart_rx};
		end
	end

	always_ff @(posedge clk_root) begin
		if (!rst_n) begin
			state <= ST_IDLE;
			tick <= '0;
			bit_idx <= '0;
			rx_strobe <= 1'b0;
		end else begin
			rx_strobe <= 1'b0;
			case (state)
				ST_IDLE: begin
					// Falling edge opens a frame
					tick <= '0;
					if (!rx_bit) begin
						state <= ST_START;
					end
				end
				ST_START: begin
					if (tick == TICK_W'(HALF_BIT - 1)) begin
						tick <= '0;
						bit_idx <= '0;
						// Glitch shorter than half a bit goes back to idle
						state <= rx_bit ? ST_IDLE : ST_DATA;
					end else begin
						tick <= tick + 1'b1;
					end
				end
				ST_DATA: begin
					if (bit_done) begin
						tick <= '0;
						bit_idx <= bit_idx + 1'b1;
						if (bit_idx == $clog2(BYTE_W)'(BYTE_W - 1)) begin
							state <= ST_STOP;
						end
					end else begin
						tick <= tick + 1'b1;
					end
				end
				default: begin
					if (bit_done) begin
						tick <= '0;
						// Framing error drops the byte silently
						rx_strobe <= rx_bit;
						state <= ST_IDLE;
					end else begin
						tick <= tick + 1'b1;
					end
				end
			endcase
		end
	end

	// LSB first on the wire
	always_ff @(posedge clk_root) begin
		if (state == ST_DATA && bit_done) begin
			shift <= {rx_bit, shift[BYTE_W-1:1]};
		end
		if (state == ST_STOP && bit_done && rx_bit) begin
			rx_data <= shift;
		end
	end

endmodule

//--- source/line_command_decoder.sv
// Command parser: line writes into the frame buffer, brightness enable, command count
`timescale 1ns/10ps

module line_command_decoder #(
	parameter int COLUMNS = 64,
	parameter int ROW_PAIRS = 16
) (
	input  logic clk_root,
	input  logic rst_n,
	input  logic [led_matrix_pkg::BYTE_W-1:0] rx_data,
	input  logic rx_strobe,
	output logic [$clog2(2*ROW_PAIRS*COLUMNS)-1:0] wr_address,
	output logic [led_matrix_pkg::BYTE_W-1:0] wr_data,
	output logic wr_lane,
	output logic wr_enable,
	output logic [led_matrix_pkg::PLANES-1:0] brightness_enable,
	output logic [7:0] commands_processed
);
	import led_matrix_pkg::*;

	localparam int ADDR_W = $clog2(2*ROW_PAIRS*COLUMNS);
	localparam int ROW_W = $clog2(2*ROW_PAIRS);
	localparam int CNT_W = $clog2(2*COLUMNS);
	localparam logic [1:0] ST_IDLE = 2'd0;
	localparam logic [1:0] ST_ROW = 2'd1;
	localparam logic [1:0] ST_PIXELS = 2'd2;
	localparam logic [1:0] ST_ENABLE = 2'd3;

	logic [1:0] state;
	logic [ROW_W-1:0] line_row;
	logic [CNT_W-1:0] byte_cnt;
	logic last_byte;

	assign last_byte = (byte_cnt == CNT_W'(2*COLUMNS - 1));

	// Write port straight from the strobe, so the byte is in memory next cycle
	assign wr_enable = rx_strobe && (state == ST_PIXELS);
	assign wr_data = rx_data;
	// Even byte is the low half of the pixel
	assign wr_lane = byte_cnt[0];
	// Pixel index is row * COLUMNS + column
	assign wr_address = ADDR_W'(line_row) * ADDR_W'(COLUMNS)
		+ ADDR_W'(byte_cnt[CNT_W-1:1]);

	always_ff @(posedge clk_root) begin
		if (!rst_n) begin
			state <= ST_IDLE;
			line_row <= '0;
			byte_cnt <= '0;
			// Every plane lit out of reset
			brightness_enable <= '1;
			commands_processed <= 8'd0;
		end else if (rx_strobe) begin
			case (state)
				ST_IDLE: begin
					// Anything but a command code is dropped here
					if (rx_data == CMD_LINE) begin
						state <= ST_ROW;
					end else if (rx_data == CMD_ENABLE) begin
						state <= ST_ENABLE;
					end
				end
				ST_ROW: begin
					// Out-of-range rows wrap onto the panel
					line_row <= ROW_W'(rx_data % (2*ROW_PAIRS));
					byte_cnt <= '0;
					state <= ST_PIXELS;
				end
				ST_PIXELS: begin
					if (last_byte) begin
						commands_processed <= commands_processed + 8'd1;
						state <= ST_IDLE;
					end else begin
						byte_cnt <= byte_cnt + 1'b1;
					end
				end
				default: begin
					brightness_enable <= rx_data[PLANES-1:0];
					commands_processed <= commands_processed + 8'd1;
					state <= ST_IDLE;
				end
			endcase
		end
	end

endmodule

//--- source/frame_buffer.sv
// Dual-port pixel RAM, byte-lane writes on port A and registered 16-bit reads on port B
`timescale 1ns/10ps

module frame_buffer #(
	parameter int COLUMNS = 64,
	parameter int ROW_PAIRS = 16
) (
	input  logic clk_root,
	input  logic [$clog2(2*ROW_PAIRS*COLUMNS)-1:0] wr_address,
	input  logic [led_matrix_pkg::BYTE_W-1:0] wr_data,
	input  logic wr_lane,
	input  logic wr_enable,
	input  logic [$clog2(2*ROW_PAIRS*COLUMNS)-1:0] rd_address,
	output logic [led_matrix_pkg::PIXEL_W-1:0] rd_data
);
	import led_matrix_pkg::*;

	// One word per pixel, both panel halves
	localparam int DEPTH = 2 * ROW_PAIRS * COLUMNS;

	logic [PIXEL_W-1:0] mem [DEPTH];

	// Lane 0 low byte, lane 1 high byte
	always_ff @(posedge clk_root) begin
		if (wr_enable) begin
			mem[wr_address][wr_lane*BYTE_W +: BYTE_W] <= wr_data;
		end
	end

	// Read data one cycle after the address
	always_ff @(posedge clk_root) begin
		rd_data <= mem[rd_address];
	end

endmodule

//--- source/matrix_scan.sv
// Panel scan sequencer: columns, planes and row pairs with pixel clock, latch and OE
`timescale 1ns/10ps

module matrix_scan #(
	parameter int COLUMNS = 64,
	parameter int ROW_PAIRS = 16,
	parameter int OE_BASE_CYCLES = 8
) (
	input  logic clk_root,
	input  logic rst_n,
	output logic [$clog2(COLUMNS)-1:0] column,
	output logic [$clog2(ROW_PAIRS)-1:0] row_address,
	output logic [$clog2(led_matrix_pkg::PLANES)-1:0] plane,
	output logic pixel_step,
	output logic clk_pixel,
	output logic row_latch,
	output logic output_enable
);
	import led_matrix_pkg::*;

	localparam int COL_W = $clog2(COLUMNS);
	localparam int ROW_W = $clog2(ROW_PAIRS);
	localparam int PLANE_W = $clog2(PLANES);
	// Wide enough for the brightest plane
	localparam int OE_W = $clog2(OE_BASE_CYCLES << (PLANES - 1)) + 1;
	localparam logic [1:0] PH_SHIFT = 2'd0;
	localparam logic [1:0] PH_LATCH = 2'd1;
	localparam logic [1:0] PH_DISPLAY = 2'd2;

	logic [1:0] phase;
	logic [1:0] pix_phase;
	logic [OE_W-1:0] oe_left;

	// Cycle 0 of each pixel
	assign pixel_step = (phase == PH_SHIFT) && (pix_phase == 2'd0);
	assign row_latch = (phase == PH_LATCH);
	assign output_enable = (phase == PH_DISPLAY);

	always_ff @(posedge clk_root) begin
		if (!rst_n) begin
			phase <= PH_SHIFT;
			pix_phase <= 2'd0;
			column <= '0;
			plane <= '0;
			// First latch loads pair 0, the shift before it already fetches pair 0
			row_address <= ROW_W'(ROW_PAIRS - 1);
			oe_left <= '0;
			clk_pixel <= 1'b0;
		end else begin
			// High in cycle 3 only
			clk_pixel <= (phase == PH_SHIFT) && (pix_phase == 2'd2);
			case (phase)
				PH_SHIFT: begin
					pix_phase <= pix_phase + 2'd1;
					if (pix_phase == 2'd3) begin
						if (column == COL_W'(COLUMNS - 1)) begin
							column <= '0;
							phase <= PH_LATCH;
						end else begin
							column <= column + 1'b1;
						end
					end
				end
				PH_LATCH: begin
					// New row pair takes effect with its plane 0 latch
					if (plane == '0) begin
						if (row_address == ROW_W'(ROW_PAIRS - 1)) begin
							row_address <= '0;
						end else begin
							row_address <= row_address + 1'b1;
						end
					end
					// Binary weighted on-time
					oe_left <= (OE_W'(OE_BASE_CYCLES) << plane) - 1'b1;
					phase <= PH_DISPLAY;
				end
				PH_DISPLAY: begin
					if (oe_left == '0) begin
						phase <= PH_SHIFT;
						if (plane == PLANE_W'(PLANES - 1)) begin
							plane <= '0;
						end else begin
							plane <= plane + 1'b1;
						end
					end else begin
						oe_left <= oe_left - 1'b1;
					end
				end
				default: begin
					phase <= PH_SHIFT;
				end
			endcase
		end
	end

endmodule

//--- source/pixel_fetch_split.sv
// Pixel fetch for both panel halves, reduced to one colour bit per channel for the plane
`timescale 1ns/10ps

module pixel_fetch_split #(
	parameter int COLUMNS = 64,
	parameter int ROW_PAIRS = 16
) (
	input  logic clk_root,
	input  logic rst_n,
	input  logic [$clog2(COLUMNS)-1:0] column,
	input  logic [$clog2(ROW_PAIRS)-1:0] row_address,
	input  logic [$clog2(led_matrix_pkg::PLANES)-1:0] plane,
	input  logic pixel_step,
	input  logic [led_matrix_pkg::PLANES-1:0] brightness_enable,
	output logic [$clog2(2*ROW_PAIRS*COLUMNS)-1:0] rd_address,
	input  logic [led_matrix_pkg::PIXEL_W-1:0] rd_data,
	output logic [2:0] rgb1,
	output logic [2:0] rgb2
);
	import led_matrix_pkg::*;

	localparam int ADDR_W = $clog2(2*ROW_PAIRS*COLUMNS);
	localparam int ROW_W = $clog2(ROW_PAIRS);

	logic [ROW_W-1:0] fetch_row;
	logic [ADDR_W-1:0] top_address;
	logic [ADDR_W-1:0] bottom_address;
	logic [PIXEL_W-1:0] top_word;
	logic step_d1;
	logic step_d2;

	// RGB565 widened to 6 bits per channel, then bit p, gated by the plane enable
	function automatic logic [2:0] colour_bits(
		input logic [PIXEL_W-1:0] word,
		input logic [$clog2(PLANES)-1:0] p,
		input logic [PLANES-1:0] en
	);
		logic [5:0] red;
		logic [5:0] green;
		logic [5:0] blue;
		red = {word[15:11], word[15]};
		green = word[10:5];
		blue = {word[4:0], word[4]};
		colour_bits = {blue[p], green[p], red[p]} & {3{en[p]}};
	endfunction

	// Plane 0 shift runs before its latch moves row_address, so look one pair ahead
	always_comb begin
		fetch_row = row_address;
		if (plane == '0) begin
			if (row_address == ROW_W'(ROW_PAIRS - 1)) begin
				fetch_row = '0;
			end else begin
				fetch_row = row_address + 1'b1;
			end
		end
	end

	assign top_address = ADDR_W'(fetch_row) * ADDR_W'(COLUMNS) + ADDR_W'(column);
	// Bottom half sits ROW_PAIRS rows further down
	assign bottom_address = top_address + ADDR_W'(ROW_PAIRS * COLUMNS);
	// Top in cycle 0, bottom for the rest of the pixel
	assign rd_address = pixel_step ? top_address : bottom_address;

	always_ff @(posedge clk_root) begin
		if (!rst_n) begin
			step_d1 <= 1'b0;
			step_d2 <= 1'b0;
			rgb1 <= 3'b000;
			rgb2 <= 3'b000;
		end else begin
			step_d1 <= pixel_step;
			step_d2 <= step_d1;
			// Bottom word sits on rd_data in cycle 2
			if (step_d2) begin
				rgb1 <= colour_bits(top_word, plane, brightness_enable);
				rgb2 <= colour_bits(rd_data, plane, brightness_enable);
			end
		end
	end

	// Top word arrives in cycle 1
	always_ff @(posedge clk_root) begin
		if (step_d1) begin
			top_word <= rd_data;
		end
	end

endmodule

//--- source/led_matrix_top.sv
// LED matrix controller top, UART in and HUB75 panel signals out
`timescale 1ns/10ps

module led_matrix_top #(
	parameter int COLUMNS = 64,
	parameter int ROW_PAIRS = 16,
	parameter int TICKS_PER_BIT = 20,
	parameter int OE_BASE_CYCLES = 8
) (
	input  logic clk_root,
	input  logic rst_n,
	input  logic uart_rx,
	output logic [$clog2(ROW_PAIRS)-1:0] row_address,
	output logic [2:0] rgb1,
	output logic [2:0] rgb2,
	output logic clk_pixel,
	output logic row_latch,
	output logic output_enable,
	output logic [7:0] commands_processed
);
	import led_matrix_pkg::*;

	localparam int ADDR_W = $clog2(2*ROW_PAIRS*COLUMNS);

	// Receiver to decoder
	logic [BYTE_W-1:0] rx_data;
	logic rx_strobe;
	// Decoder write port
	logic [ADDR_W-1:0] wr_address;
	logic [BYTE_W-1:0] wr_data;
	logic wr_lane;
	logic wr_enable;
	logic [PLANES-1:0] brightness_enable;
	// Fetch read port
	logic [ADDR_W-1:0] rd_address;
	logic [PIXEL_W-1:0] rd_data;
	// Scan position
	logic [$clog2(COLUMNS)-1:0] column;
	logic [$clog2(PLANES)-1:0] plane;
	logic pixel_step;

	uart_byte_rx #(
		.TICKS_PER_BIT(TICKS_PER_BIT)
	) u_rx (
		.clk_root(clk_root),
		.rst_n(rst_n),
		.uart_rx(uart_rx),
		.rx_data(rx_data),
		.rx_strobe(rx_strobe)
	);

	line_command_decoder #(
		.COLUMNS(COLUMNS),
		.ROW_PAIRS(ROW_PAIRS)
	) u_decoder (
		.clk_root(clk_root),
		.rst_n(rst_n),
		.rx_data(rx_data),
		.rx_strobe(rx_strobe),
		.wr_address(wr_address),
		.wr_data(wr_data),
		.wr_lane(wr_lane),
		.wr_enable(wr_enable),
		.brightness_enable(brightness_enable),
		.commands_processed(commands_processed)
	);

	frame_buffer #(
		.COLUMNS(COLUMNS),
		.ROW_PAIRS(ROW_PAIRS)
	) u_buffer (
		.clk_root(clk_root),
		.wr_address(wr_address),
		.wr_data(wr_data),
		.wr_lane(wr_lane),
		.wr_enable(wr_enable),
		.rd_address(rd_address),
		.rd_data(rd_data)
	);

	matrix_scan #(
		.COLUMNS(COLUMNS),
		.ROW_PAIRS(ROW_PAIRS),
		.OE_BASE_CYCLES(OE_BASE_CYCLES)
	) u_scan (
		.clk_root(clk_root),
		.rst_n(rst_n),
		.column(column),
		.row_address(row_address),
		.plane(plane),
		.pixel_step(pixel_step),
		.clk_pixel(clk_pixel),
		.row_latch(row_latch),
		.output_enable(output_enable)
	);

	pixel_fetch_split #(
		.COLUMNS(COLUMNS),
		.ROW_PAIRS(ROW_PAIRS)
	) u_fetch (
		.clk_root(clk_root),
		.rst_n(rst_n),
		.column(column),
		.row_address(row_address),
		.plane(plane),
		.pixel_step(pixel_step),
		.brightness_enable(brightness_enable),
		.rd_address(rd_address),
		.rd_data(rd_data),
		.rgb1(rgb1),
		.rgb2(rgb2)
	);

endmodule

//--- sim/led_matrix_chk.sv
// Panel timing assertions on the scan sequencer outputs
`timescale 1ns/10ps

module led_matrix_chk #(
	parameter int ROW_PAIRS = 16
) (
	input  logic clk_root,
	input  logic rst_n,
	input  logic [$clog2(ROW_PAIRS)-1:0] row_address,
	input  logic clk_pixel,
	input  logic row_latch,
	input  logic output_enable
);

	// Count of failed assertions
	int unsigned failures = 0;

	// Latch and display never overlap
	latch_oe_exclusive: assert property (
		@(posedge clk_root) disable iff (!rst_n) !(row_latch && output_enable)
	) else begin
		failures++;
		$error("row_latch and output_enable high in the same cycle");
	end

	// No pixel clock while latching or lit
	clk_quiet: assert property (
		@(posedge clk_root) disable iff (!rst_n) (row_latch || output_enable) |-> !clk_pixel
	) else begin
		failures++;
		$error("clk_pixel high during latch or display");
	end

	// Address moves only on the edge that ends a latch
	row_stable: assert property (
		@(posedge clk_root) disable iff (!rst_n) !$past(row_latch) |-> $stable(row_address)
	) else begin
		failures++;
		$error("row_address changed outside a latch");
	end

endmodule

//--- sim/tb_led_matrix.sv
// Testbench for the LED matrix controller, UART byte driver with an image model and panel monitors
`timescale 1ns/10ps

module tb_led_matrix;
	import led_matrix_pkg::*;

	localparam int COLUMNS = 8;
	localparam int ROW_PAIRS = 4;
	localparam int TICKS_PER_BIT = 4;
	localparam int OE_BASE_CYCLES = 8;
	localparam int ROW_W = $clog2(ROW_PAIRS);
	localparam int PIXELS = 2 * ROW_PAIRS * COLUMNS;
	// Model parser states
	localparam int M_IDLE = 0;
	localparam int M_ROW = 1;
	localparam int M_PIXELS = 2;
	localparam int M_ENABLE = 3;

	logic clk_root;
	logic rst_n;
	logic uart_rx;
	logic [ROW_W-1:0] row_address;
	logic [2:0] rgb1;
	logic [2:0] rgb2;
	logic clk_pixel;
	logic row_latch;
	logic output_enable;
	logic [7:0] commands_processed;

	// Tag nibble and data byte per record
	logic [11:0] vectors [256];
	// Image and enable mask as the panel should show them
	logic [PIXEL_W-1:0] image [PIXELS];
	logic [PLANES-1:0] model_enable;
	int model_state;
	int model_row;
	int model_byte;
	integer seed;
	// Scan position expected by the monitor
	int exp_pair;
	int exp_plane;
	int col;
	int oe_cnt;
	int frames_done;
	logic rgb_on;
	int cycle_count;
	int cycle_limit;

	led_matrix_top #(
		.COLUMNS(COLUMNS),
		.ROW_PAIRS(ROW_PAIRS),
		.TICKS_PER_BIT(TICKS_PER_BIT),
		.OE_BASE_CYCLES(OE_BASE_CYCLES)
	) dut (
		.clk_root(clk_root),
		.rst_n(rst_n),
		.uart_rx(uart_rx),
		.row_address(row_address),
		.rgb1(rgb1),
		.rgb2(rgb2),
		.clk_pixel(clk_pixel),
		.row_latch(row_latch),
		.output_enable(output_enable),
		.commands_processed(commands_processed)
	);

	// Panel timing properties on the scan sequencer
	bind matrix_scan led_matrix_chk #(
		.ROW_PAIRS(ROW_PAIRS)
	) u_timing_chk (
		.clk_root(clk_root),
		.rst_n(rst_n),
		.row_address(row_address),
		.clk_pixel(clk_pixel),
		.row_latch(row_latch),
		.output_enable(output_enable)
	);

	// 40 ns period
	always #20 clk_root = ~clk_root;

	task automatic stop_with_failure(input string reason);
		$display("%s", reason);
		$display("*** TEST FAILED ***");
		$fatal(1);
	endtask

	task automatic check_rgb(input string name, input logic [2:0] actual,
		input logic [2:0] expected);
		if (actual !== expected) begin
			stop_with_failure($sformatf("Fail %s: got %h expected %h", name, actual, expected));
		end
	endtask

	task automatic check_row(input logic [ROW_W-1:0] actual, input logic [ROW_W-1:0] expected);
		if (actual !== expected) begin
			stop_with_failure($sformatf("Fail row_address: got %h expected %h", actual, expected));
		end
	endtask

	task automatic check_count(input logic [7:0] actual, input logic [7:0] expected);
		if (actual !== expected) begin
			stop_with_failure($sformatf("Fail commands_processed: got %h expected %h",
				actual, expected));
		end
	endtask

	task automatic check_oe_width(input integer actual, input integer expected);
		if (actual !== expected) begin
			stop_with_failure($sformatf("Fail output_enable width: got %h expected %h",
				actual, expected));
		end
	endtask

	task automatic check_clock_count(input integer actual, input integer expected);
		if (actual !== expected) begin
			stop_with_failure($sformatf("Fail clk_pixel pulses before latch: got %h expected %h",
				actual, expected));
		end
	endtask

	// Bit p of each channel widened to 6 bits
	// Red and blue repeat their top bit as bit 0, a disabled plane is blank
	function automatic logic [2:0] plane_bits(input logic [PIXEL_W-1:0] word, input int p,
		input logic [PLANES-1:0] enable);
		logic red_bit;
		logic green_bit;
		logic blue_bit;
		green_bit = word[5 + p];
		if (p == 0) begin
			red_bit = word[15];
			blue_bit = word[4];
		end else begin
			red_bit = word[10 + p];
			blue_bit = word[p - 1];
		end
		if (enable[p]) begin
			plane_bits = {blue_bit, green_bit, red_bit};
		end else begin
			plane_bits = 3'b000;
		end
	endfunction

	// Shift, latch and display cycles of every plane of every row pair
	function automatic int frame_length();
		int total;
		total = 0;
		for (int p = 0; p < PLANES; p++) begin
			total += 4 * COLUMNS + 1 + (OE_BASE_CYCLES << p);
		end
		frame_length = total * ROW_PAIRS;
	endfunction

	// Command grammar applied to every byte sent
	task automatic update_model(input logic [7:0] value);
		int pix;
		case (model_state)
			M_IDLE: begin
				if (value == CMD_LINE) begin
					model_state = M_ROW;
				end else if (value == CMD_ENABLE) begin
					model_state = M_ENABLE;
				end
			end
			M_ROW: begin
				model_row = value % (2 * ROW_PAIRS);
				model_byte = 0;
				model_state = M_PIXELS;
			end
			M_PIXELS: begin
				pix = model_row * COLUMNS + model_byte / 2;
				// Low byte first
				if (model_byte % 2 == 0) begin
					image[pix][7:0] = value;
				end else begin
					image[pix][15:8] = value;
				end
				model_byte++;
				if (model_byte == 2 * COLUMNS) begin
					model_state = M_IDLE;
				end
			end
			default: begin
				model_enable = value[PLANES-1:0];
				model_state = M_IDLE;
			end
		endcase
	endtask

	// 8N1, LSB first, one bit per TICKS_PER_BIT cycles
	task automatic send_byte(input logic [7:0] value);
		logic [9:0] frame;
		frame = {1'b1, value, 1'b0};
		for (int i = 0; i < 10; i++) begin
			@(negedge clk_root);
			uart_rx = frame[i];
			repeat (TICKS_PER_BIT - 1) @(negedge clk_root);
		end
		update_model(value);
	endtask

	// Colour checks run over whole frames only
	task automatic watch_frames(input int count);
		int start;
		start = frames_done;
		wait (frames_done == start + 1);
		rgb_on = 1'b1;
		wait (frames_done == start + 1 + count);
		rgb_on = 1'b0;
	endtask

	// Counter moves shortly after the last byte of a command
	task automatic expect_count(input logic [7:0] value);
		int waited;
		waited = 0;
		while (commands_processed !== value && waited < 20 * TICKS_PER_BIT) begin
			@(negedge clk_root);
			waited++;
		end
		check_count(commands_processed, value);
	endtask

	always @(posedge clk_root) begin
		cycle_count++;
		if (cycle_limit != 0 && cycle_count > cycle_limit) begin
			stop_with_failure($sformatf("Run did not finish within %0d cycles", cycle_limit));
		end
	end

	// Panel monitor sampling in the middle of each cycle
	always @(negedge clk_root) begin : panel_monitor
		logic [PIXEL_W-1:0] top_word;
		logic [PIXEL_W-1:0] bottom_word;
		if (rst_n) begin
			if (dut.u_scan.u_timing_chk.failures != 0) begin
				stop_with_failure("A panel timing assertion fired");
			end
			// rgb is updated on the same edge that raises clk_pixel
			if (clk_pixel) begin
				if (rgb_on) begin
					top_word = image[exp_pair * COLUMNS + col];
					bottom_word = image[(exp_pair + ROW_PAIRS) * COLUMNS + col];
					check_rgb($sformatf("rgb1 pair %0d plane %0d column %0d", exp_pair, exp_plane,
						col), rgb1, plane_bits(top_word, exp_plane, model_enable));
					check_rgb($sformatf("rgb2 pair %0d plane %0d column %0d", exp_pair, exp_plane,
						col), rgb2, plane_bits(bottom_word, exp_plane, model_enable));
				end
				col++;
			end
			if (row_latch) begin
				check_clock_count(col, COLUMNS);
				col = 0;
			end else if (output_enable) begin
				// Address loaded by the latch shows in the first display cycle
				if (oe_cnt == 0) begin
					check_row(row_address, ROW_W'(exp_pair));
				end
				oe_cnt++;
			end else if (oe_cnt != 0) begin
				check_oe_width(oe_cnt, OE_BASE_CYCLES << exp_plane);
				oe_cnt = 0;
				// Planes 0 to 5 per pair, pairs ascending and wrapping
				if (exp_plane == PLANES - 1) begin
					exp_plane = 0;
					if (exp_pair == ROW_PAIRS - 1) begin
						exp_pair = 0;
						frames_done++;
					end else begin
						exp_pair++;
					end
				end else begin
					exp_plane++;
				end
			end
		end
	end

	initial begin : stimulus
		int idx;
		int sent;
		int frames;
		logic [31:0] rand_word;
		logic [3:0] tag;
		logic [7:0] value;
		clk_root = 1'b0;
		rst_n = 1'b0;
		uart_rx = 1'b1;
		seed = 32'h6969;
		model_enable = '1;
		model_state = M_IDLE;
		model_row = 0;
		model_byte = 0;
		exp_pair = 0;
		exp_plane = 0;
		col = 0;
		oe_cnt = 0;
		frames_done = 0;
		rgb_on = 1'b0;
		cycle_count = 0;
		cycle_limit = 0;
		$readmemh("sim/line_vectors.txt", vectors);
		// Bytes at 10 bits each, watched frames plus one to find a frame start
		sent = 0;
		frames = 0;
		idx = 0;
		while (idx < 256 && vectors[idx] !== 12'h000) begin
			case (vectors[idx][11:8])
				4'h1: sent += 1;
				4'h2: sent += vectors[idx][7:0];
				4'h3: frames += vectors[idx][7:0] + 1;
				default: ;
			endcase
			idx++;
		end
		cycle_limit = sent * 10 * TICKS_PER_BIT + frames * frame_length() + frame_length() + 2000;
		repeat (2) @(negedge clk_root);
		rst_n = 1'b1;
		idx = 0;
		while (vectors[idx] !== 12'h000) begin
			tag = vectors[idx][11:8];
			value = vectors[idx][7:0];
			case (tag)
				4'h1: send_byte(value);
				4'h2: begin
					repeat (value) begin
						rand_word = $random(seed);
						send_byte(rand_word[7:0]);
					end
				end
				4'h3: watch_frames(value);
				4'h4: expect_count(value);
				default: stop_with_failure($sformatf("Unknown record at line entry %0d", idx));
			endcase
			idx++;
		end
		if (dut.u_scan.u_timing_chk.failures == 0) begin
			$display("*** TEST PASSED ***");
			$finish;
		end else begin
			$display("A panel timing assertion fired");
			$display("*** TEST FAILED ***");
			$fatal(1);
		end
	end

endmodule

//--- sim/line_vectors.txt
// Each entry is a tag nibble and a byte: 1 send byte, 2 send that many random bytes,
// 3 watch that many full frames, 4 expected commands_processed, 000 ends the list
155
14C 100 210
14C 101 210
14C 102 210
14C 103 210
14C 104 210
14C 105 210
14C 106 210
14C 107 210
408
301
145 12D
409
301
14C 10B 210
40A
100 17A
145 13F
40B
302
000

//--- sim.f
source/led_matrix_pkg.sv
source/uart_byte_rx.sv
source/line_command_decoder.sv
source/frame_buffer.sv
source/matrix_scan.sv
source/pixel_fetch_split.sv
source/led_matrix_top.sv
sim/led_matrix_chk.sv
sim/tb_led_matrix.sv

//--- Bender.yml
package:
  name: led_matrix

sources:
  - source/led_matrix_pkg.sv
  - source/uart_byte_rx.sv
  - source/line_command_decoder.sv
  - source/frame_buffer.sv
  - source/matrix_scan.sv
  - source/pixel_fetch_split.sv
  - source/led_matrix_top.sv
  - target: simulation
    files:
      - sim/led_matrix_chk.sv
      - sim/tb_led_matrix.sv
